// ==== logic/bus_pkg.sv ====
// register bus widths and address map, channel and offset fields only, upper address bits ignored
`default_nettype none

package bus_pkg;

    // ------------------------------
    // bus widths
    // ------------------------------
    localparam int ADDR_W = 16;                 // register address
    localparam int DATA_W = 32;                 // register data

    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0] reg_data_t;

    // ------------------------------
    // address fields
    // ------------------------------
    localparam int CHAN_LSB = 4;                // channel field low bit
    localparam int CHAN_MSB = 7;                // channel field high bit
    localparam int OFF_MSB  = 3;                // offset field is [OFF_MSB:0]

    typedef logic [CHAN_MSB-CHAN_LSB:0] chan_t;
    typedef logic [OFF_MSB:0]           off_t;

    localparam chan_t CHAN_BOARD = '0;          // channel 0 is the board

    // offsets within a channel
    localparam off_t OFF_BOARD_STATUS = 4'd0;   // status on read, control on write
    localparam off_t OFF_DAC_CMD      = 4'd0;   // axis current command
    localparam off_t OFF_ADC_FB       = 4'd1;   // axis current feedback, read only

    // ------------------------------
    // board word bit positions
    // ------------------------------
    localparam int CTRL_PWR_BIT    = 0;         // power enable
    localparam int CTRL_AMP_LSB    = 4;         // amp enable requests, one per axis
    localparam int STAT_SAFETY_LSB = 8;         // sticky safety disables
    localparam int STAT_ID_LSB     = 24;        // rotary switch id
    localparam int ID_W            = 4;

endpackage

`default_nettype wire

// ==== logic/axis_pkg.sv ====
// axis count and current format, currents are unsigned magnitudes with no sign handling
`default_nettype none

package axis_pkg;

    // ------------------------------
    // axes and current words
    // ------------------------------
    localparam int NUM_AXES = 4;        // axes 1..4 on channels 1..4
    localparam int CUR_W    = 16;       // dac and adc word width

    typedef logic [CUR_W-1:0]    cur_t;       // one current sample or command
    typedef logic [NUM_AXES-1:0] axis_vec_t;  // bit 0 is axis 1

    // ------------------------------
    // safety check
    // ------------------------------
    // consecutive cycles of fb > 2*cmd before the amp is cut
    localparam int OVERCURRENT_CYCLES = 8;

    // persistence counter width, holds 0..OVERCURRENT_CYCLES
    localparam int OC_CNT_W = $clog2(OVERCURRENT_CYCLES + 1);

endpackage

`default_nettype wire

// ==== logic/reg_bus_if.sv ====
// one register slave port, reads are combinational from addr and wen is a single cycle strobe
`default_nettype none

interface reg_bus_if;

    logic               wen;    // write strobe, one cycle
    bus_pkg::reg_addr_t addr;   // held for the whole access
    bus_pkg::reg_data_t wdata;
    bus_pkg::reg_data_t rdata;  // from slave, zero when unmapped

    // arbiter side
    modport master (
        output wen,
        output addr,
        output wdata,
        input  rdata
    );

    // register block side
    modport slave (
        input  wen,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== logic/bus_arbiter.sv ====
// two host arbiter with four phase req and ack, ethernet wins a tie, one access in flight at a time
`default_nettype none

module bus_arbiter (
    input  wire                        sysclk,
    input  wire                        rst_n,

    // firewire host
    input  wire                        fw_req,
    input  wire                        fw_write,
    input  wire bus_pkg::reg_addr_t    fw_addr,
    input  wire bus_pkg::reg_data_t    fw_wdata,
    output logic                       fw_ack,
    output bus_pkg::reg_data_t         fw_rdata,

    // ethernet host
    input  wire                        eth_req,
    input  wire                        eth_write,
    input  wire bus_pkg::reg_addr_t    eth_addr,
    input  wire bus_pkg::reg_data_t    eth_wdata,
    output logic                       eth_ack,
    output bus_pkg::reg_data_t         eth_rdata,

    reg_bus_if.master                  board_bus,
    reg_bus_if.master                  axis_bus
);

    typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_ACK} state_t;

    state_t             state;
    logic               eth_sel;    // granted host, 1 = ethernet
    logic               write_q;
    bus_pkg::reg_addr_t addr_q;
    bus_pkg::reg_data_t wdata_q;
    logic               grant;
    logic               host_req;   // req of granted host
    logic               host_ack;   // ack of granted host
    bus_pkg::chan_t     chan;
    logic               sel_board;
    logic               sel_axis;
    bus_pkg::reg_data_t rd_mux;

    assign grant    = (state == ST_IDLE) && (fw_req || eth_req);
    assign host_req = eth_sel ? eth_req : fw_req;
    assign host_ack = eth_sel ? eth_ack : fw_ack;

    // ------------------------------
    // address decode
    // ------------------------------
    assign chan      = addr_q[bus_pkg::CHAN_MSB:bus_pkg::CHAN_LSB];
    assign sel_board = (chan == bus_pkg::CHAN_BOARD);
    assign sel_axis  = !sel_board && (int'(chan) <= axis_pkg::NUM_AXES);  // chan 1..4

    assign board_bus.addr  = addr_q;
    assign board_bus.wdata = wdata_q;
    assign board_bus.wen   = (state == ST_ACCESS) && write_q && sel_board;
    assign axis_bus.addr   = addr_q;
    assign axis_bus.wdata  = wdata_q;
    assign axis_bus.wen    = (state == ST_ACCESS) && write_q && sel_axis;

    assign rd_mux = sel_board ? board_bus.rdata :
                    sel_axis  ? axis_bus.rdata  : '0;   // unmapped channel reads zero

    // ------------------------------
    // state machine
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            eth_sel <= 1'b0;
            write_q <= 1'b0;
            fw_ack  <= 1'b0;
            eth_ack <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (grant) begin
                        eth_sel <= eth_req;                     // eth has priority
                        write_q <= eth_req ? eth_write : fw_write;
                        state   <= ST_ACCESS;
                    end
                end
                ST_ACCESS: state <= ST_ACK;                     // wen / read capture cycle
                ST_ACK: begin
                    if (!host_ack) begin
                        fw_ack  <= !eth_sel;                    // second edge after grant
                        eth_ack <= eth_sel;
                    end else if (!host_req) begin
                        fw_ack  <= 1'b0;                        // host let go
                        eth_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request payload, latched at grant
    always_ff @(posedge sysclk) begin
        if (grant) begin
            addr_q  <= eth_req ? eth_addr : fw_addr;
            wdata_q <= eth_req ? eth_wdata : fw_wdata;
        end
    end

    // read data per host, held through ack
    always_ff @(posedge sysclk) begin
        if (state == ST_ACCESS && !write_q) begin
            if (eth_sel) eth_rdata <= rd_mux;
            else         fw_rdata  <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== logic/axis_regs.sv ====
// per axis command and feedback registers on channels 1 to 4, commands use the low CUR_W bits only
`default_nettype none

module axis_regs (
    input  wire                        sysclk,
    input  wire                        rst_n,

    reg_bus_if.slave                   bus,

    input  wire axis_pkg::cur_t        cur_fb [axis_pkg::NUM_AXES],   // from adcs
    output axis_pkg::cur_t             dac_cmd [axis_pkg::NUM_AXES],  // to dacs
    output axis_pkg::axis_vec_t        cmd_written                    // one pulse per write
);

    bus_pkg::chan_t      chan;
    bus_pkg::off_t       off;
    axis_pkg::axis_vec_t axis_hit;   // channel i+1 addressed
    bus_pkg::reg_data_t  rd;

    assign chan = bus.addr[bus_pkg::CHAN_MSB:bus_pkg::CHAN_LSB];
    assign off  = bus.addr[bus_pkg::OFF_MSB:0];

    // ------------------------------
    // channel decode
    // ------------------------------
    always_comb begin
        for (int i = 0; i < axis_pkg::NUM_AXES; i++) begin
            axis_hit[i] = (chan == bus_pkg::chan_t'(i + 1));   // axis 1 on channel 1
        end
    end

    // same cycle as wen, timer clears on it
    assign cmd_written = axis_hit & {axis_pkg::NUM_AXES{bus.wen && (off == bus_pkg::OFF_DAC_CMD)}};

    // ------------------------------
    // command registers
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < axis_pkg::NUM_AXES; i++) begin
                dac_cmd[i] <= '0;                               // amps at zero current
            end
        end else begin
            for (int i = 0; i < axis_pkg::NUM_AXES; i++) begin
                if (cmd_written[i]) begin
                    dac_cmd[i] <= bus.wdata[axis_pkg::CUR_W-1:0];   // upper bits dropped
                end
            end
        end
    end

    // ------------------------------
    // read mux
    // ------------------------------
    always_comb begin
        rd = '0;
        for (int i = 0; i < axis_pkg::NUM_AXES; i++) begin
            if (axis_hit[i]) begin
                case (off)
                    bus_pkg::OFF_DAC_CMD: rd = bus_pkg::reg_data_t'(dac_cmd[i]);
                    bus_pkg::OFF_ADC_FB:  rd = bus_pkg::reg_data_t'(cur_fb[i]);
                    default:              rd = '0;              // unused offsets
                endcase
            end
        end
    end

    assign bus.rdata = rd;

endmodule

`default_nettype wire

// ==== logic/overcurrent_timer.sv ====
// per axis overcurrent check on fb greater than twice cmd, flags stay set until that axis command is rewritten
`default_nettype none

module overcurrent_timer (
    input  wire                        sysclk,
    input  wire                        rst_n,

    input  wire axis_pkg::cur_t        cur_fb [axis_pkg::NUM_AXES],
    input  wire axis_pkg::cur_t        dac_cmd [axis_pkg::NUM_AXES],
    input  wire axis_pkg::axis_vec_t   cmd_written,      // clears count and flag
    output axis_pkg::axis_vec_t        safety_disable    // sticky, one per axis
);

    logic [axis_pkg::OC_CNT_W-1:0] count [axis_pkg::NUM_AXES];
    axis_pkg::axis_vec_t           over;

    // ------------------------------
    // limit compare
    // ------------------------------
    // one extra bit so 2*cmd never wraps
    always_comb begin
        for (int i = 0; i < axis_pkg::NUM_AXES; i++) begin
            over[i] = {1'b0, cur_fb[i]} > {dac_cmd[i], 1'b0};   // equal is not over
        end
    end

    // ------------------------------
    // persistence counters
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < axis_pkg::NUM_AXES; i++) begin
                count[i] <= '0;
            end
            safety_disable <= '0;
        end else begin
            for (int i = 0; i < axis_pkg::NUM_AXES; i++) begin
                if (cmd_written[i]) begin
                    count[i]          <= '0;                    // new command rearms
                    safety_disable[i] <= 1'b0;
                end else if (over[i]) begin
                    if (count[i] != axis_pkg::OVERCURRENT_CYCLES) begin
                        count[i] <= count[i] + 1'b1;            // saturates at limit
                    end
                    if (count[i] == axis_pkg::OVERCURRENT_CYCLES - 1) begin
                        safety_disable[i] <= 1'b1;              // count reaches limit
                    end
                end else begin
                    count[i] <= '0;                             // streak broken
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/board_regs.sv ====
// channel 0 control and status at offset 0 only, other board offsets read zero and ignore writes
`default_nettype none

module board_regs (
    input  wire                        sysclk,
    input  wire                        rst_n,

    reg_bus_if.slave                   bus,

    input  wire [bus_pkg::ID_W-1:0]    board_id,        // rotary switch
    input  wire axis_pkg::axis_vec_t   safety_disable,  // from overcurrent timer
    output axis_pkg::axis_vec_t        amp_enable,
    output logic                       pwr_enable
);

    axis_pkg::axis_vec_t amp_req;   // host enable requests
    logic                hit;       // board status offset addressed
    bus_pkg::reg_data_t  status;

    assign hit = (bus.addr[bus_pkg::CHAN_MSB:bus_pkg::CHAN_LSB] == bus_pkg::CHAN_BOARD) &&
                 (bus.addr[bus_pkg::OFF_MSB:0] == bus_pkg::OFF_BOARD_STATUS);

    // ------------------------------
    // control register
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_enable <= 1'b0;
            amp_req    <= '0;
        end else if (bus.wen && hit) begin
            pwr_enable <= bus.wdata[bus_pkg::CTRL_PWR_BIT];
            amp_req    <= bus.wdata[bus_pkg::CTRL_AMP_LSB +: axis_pkg::NUM_AXES];
        end
    end

    // amp only on with power up and no safety trip
    assign amp_enable = amp_req & ~safety_disable & {axis_pkg::NUM_AXES{pwr_enable}};

    // ------------------------------
    // status word
    // ------------------------------
    always_comb begin
        status = '0;
        status[bus_pkg::CTRL_PWR_BIT]                            = pwr_enable;
        status[bus_pkg::CTRL_AMP_LSB +: axis_pkg::NUM_AXES]      = amp_req;
        status[bus_pkg::STAT_SAFETY_LSB +: axis_pkg::NUM_AXES]   = safety_disable;
        status[bus_pkg::STAT_ID_LSB +: bus_pkg::ID_W]            = board_id;
    end

    assign bus.rdata = hit ? status : '0;

endmodule

`default_nettype wire

// ==== logic/motor_ctrl_top.sv ====
// register access core with two host ports, feedback and commands are parallel words with no adc or dac engines
`default_nettype none

module motor_ctrl_top (
    input  wire                        sysclk,
    input  wire                        rst_n,
    input  wire [bus_pkg::ID_W-1:0]    board_id,

    // firewire side host
    input  wire                        fw_req,
    input  wire                        fw_write,
    input  wire bus_pkg::reg_addr_t    fw_addr,
    input  wire bus_pkg::reg_data_t    fw_wdata,
    output logic                       fw_ack,
    output bus_pkg::reg_data_t         fw_rdata,

    // ethernet side host
    input  wire                        eth_req,
    input  wire                        eth_write,
    input  wire bus_pkg::reg_addr_t    eth_addr,
    input  wire bus_pkg::reg_data_t    eth_wdata,
    output logic                       eth_ack,
    output bus_pkg::reg_data_t         eth_rdata,

    // axis i/o
    input  wire axis_pkg::cur_t        cur_fb [axis_pkg::NUM_AXES],
    output axis_pkg::cur_t             dac_cmd [axis_pkg::NUM_AXES],
    output axis_pkg::axis_vec_t        amp_enable,
    output logic                       pwr_enable
);

    // ------------------------------
    // local wires
    // ------------------------------
    reg_bus_if board_bus ();   // channel 0
    reg_bus_if axis_bus ();    // channels 1..4

    axis_pkg::axis_vec_t cmd_written;      // command write pulses
    axis_pkg::axis_vec_t safety_disable;   // timer trips

    bus_arbiter u_arbiter (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .fw_req    (fw_req),
        .fw_write  (fw_write),
        .fw_addr   (fw_addr),
        .fw_wdata  (fw_wdata),
        .fw_ack    (fw_ack),
        .fw_rdata  (fw_rdata),
        .eth_req   (eth_req),
        .eth_write (eth_write),
        .eth_addr  (eth_addr),
        .eth_wdata (eth_wdata),
        .eth_ack   (eth_ack),
        .eth_rdata (eth_rdata),
        .board_bus (board_bus.master),
        .axis_bus  (axis_bus.master)
    );

    board_regs u_board (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .bus            (board_bus.slave),
        .board_id       (board_id),
        .safety_disable (safety_disable),
        .amp_enable     (amp_enable),
        .pwr_enable     (pwr_enable)
    );

    axis_regs u_axis (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .bus         (axis_bus.slave),
        .cur_fb      (cur_fb),
        .dac_cmd     (dac_cmd),
        .cmd_written (cmd_written)
    );

    // fb vs 2*cmd per axis
    overcurrent_timer u_safety (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .cur_fb         (cur_fb),
        .dac_cmd        (dac_cmd),
        .cmd_written    (cmd_written),
        .safety_disable (safety_disable)
    );

endmodule

`default_nettype wire

// ==== testbench/motor_ctrl_checker.sv ====
// bound into motor_ctrl_top and silent in reset with taps on internal safety flags and write pulses
`default_nettype none

module motor_ctrl_checker (
    input  wire                        sysclk,
    input  wire                        rst_n,
    input  wire                        fw_req,
    input  wire                        fw_ack,
    input  wire bus_pkg::reg_data_t    fw_rdata,
    input  wire                        eth_req,
    input  wire                        eth_ack,
    input  wire bus_pkg::reg_data_t    eth_rdata,
    input  wire axis_pkg::cur_t        cur_fb [axis_pkg::NUM_AXES],
    input  wire axis_pkg::cur_t        dac_cmd [axis_pkg::NUM_AXES],
    input  wire axis_pkg::axis_vec_t   cmd_written,
    input  wire axis_pkg::axis_vec_t   amp_enable,
    input  wire axis_pkg::axis_vec_t   safety_disable
);

    int                  fail_cnt = 0;   // read by the testbench at the end
    axis_pkg::axis_vec_t over_lim;       // fb above twice cmd

    // ------------------------------
    // handshake
    // ------------------------------
    // ack only answers a request that was up
    fw_ack_rise: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(fw_ack) |-> $past(fw_req))
        else begin
            fail_cnt++;
            $error("fw ack rose with fw req low");
        end
    eth_ack_rise: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(eth_ack) |-> $past(eth_req))
        else begin
            fail_cnt++;
            $error("eth ack rose with eth req low");
        end

    // ack released only once the host let go
    fw_ack_fall: assert property (@(posedge sysclk) disable iff (!rst_n)
        $fell(fw_ack) |-> !$past(fw_req))
        else begin
            fail_cnt++;
            $error("fw ack fell while fw req high");
        end
    eth_ack_fall: assert property (@(posedge sysclk) disable iff (!rst_n)
        $fell(eth_ack) |-> !$past(eth_req))
        else begin
            fail_cnt++;
            $error("eth ack fell while eth req high");
        end

    // read data frozen through the ack phase
    fw_rdata_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        (fw_ack && $past(fw_ack)) |-> $stable(fw_rdata))
        else begin
            fail_cnt++;
            $error("fw rdata changed during ack");
        end
    eth_rdata_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        (eth_ack && $past(eth_ack)) |-> $stable(eth_rdata))
        else begin
            fail_cnt++;
            $error("eth rdata changed during ack");
        end

    // ------------------------------
    // safety
    // ------------------------------
    always_comb begin
        for (int i = 0; i < axis_pkg::NUM_AXES; i++) begin
            over_lim[i] = int'(cur_fb[i]) > 2 * int'(dac_cmd[i]);   // equal is allowed
        end
    end

    // a run of over limit cycles with no rewrite trips the flag and cuts the amp
    for (genvar i = 0; i < axis_pkg::NUM_AXES; i++) begin : g_trip
        amp_vs_trip: assert property (@(posedge sysclk) disable iff (!rst_n)
            (over_lim[i] && !cmd_written[i]) [*axis_pkg::OVERCURRENT_CYCLES]
                |=> (safety_disable[i] && !amp_enable[i]))
            else begin
                fail_cnt++;
                $error("axis %0d amp not cut after a persistent overcurrent", i + 1);
            end
    end

endmodule

bind motor_ctrl_top motor_ctrl_checker u_checker (
    .sysclk         (sysclk),
    .rst_n          (rst_n),
    .fw_req         (fw_req),
    .fw_ack         (fw_ack),
    .fw_rdata       (fw_rdata),
    .eth_req        (eth_req),
    .eth_ack        (eth_ack),
    .eth_rdata      (eth_rdata),
    .cur_fb         (cur_fb),
    .dac_cmd        (dac_cmd),
    .cmd_written    (cmd_written),      // internal command write pulses
    .amp_enable     (amp_enable),
    .safety_disable (safety_disable)   // internal timer output
);

`default_nettype wire

// ==== testbench/tb_motor_ctrl.sv ====
// drives both hosts with four phase handshakes, each wait gives up after 20 cycles, inputs move 2 after the edge
`default_nettype none

module tb_motor_ctrl;

    logic                     sysclk;
    logic                     rst_n;
    logic [bus_pkg::ID_W-1:0] board_id;
    logic                     fw_req;
    logic                     fw_write;
    bus_pkg::reg_addr_t       fw_addr;
    bus_pkg::reg_data_t       fw_wdata;
    logic                     fw_ack;
    bus_pkg::reg_data_t       fw_rdata;
    logic                     eth_req;
    logic                     eth_write;
    bus_pkg::reg_addr_t       eth_addr;
    bus_pkg::reg_data_t       eth_wdata;
    logic                     eth_ack;
    bus_pkg::reg_data_t       eth_rdata;
    axis_pkg::cur_t           cur_fb [axis_pkg::NUM_AXES];
    axis_pkg::cur_t           dac_cmd [axis_pkg::NUM_AXES];
    axis_pkg::axis_vec_t      amp_enable;
    logic                     pwr_enable;

    int                       err_cnt = 0;
    int                       tmo_cnt = 0;
    integer                   seed = 32'hd61bf0fc;
    axis_pkg::cur_t           cmd_model [axis_pkg::NUM_AXES];   // last written commands
    bus_pkg::reg_data_t       rd;
    bus_pkg::reg_data_t       rd_fw;
    bus_pkg::reg_data_t       rd_eth;
    time                      t_fw;
    time                      t_eth;

    motor_ctrl_top u_dut (.*);

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;   // period 40
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic bus_pkg::reg_addr_t reg_addr(input int chan, input int off);
        bus_pkg::reg_addr_t a;
        a = '0;
        a[bus_pkg::CHAN_MSB:bus_pkg::CHAN_LSB] = bus_pkg::chan_t'(chan);
        a[bus_pkg::OFF_MSB:0] = bus_pkg::off_t'(off);
        return a;
    endfunction

    function automatic bus_pkg::reg_data_t ctrl_word(input logic pwr,
                                                     input axis_pkg::axis_vec_t amp);
        bus_pkg::reg_data_t w;
        w = '0;
        w[bus_pkg::CTRL_PWR_BIT] = pwr;
        w[bus_pkg::CTRL_AMP_LSB +: axis_pkg::NUM_AXES] = amp;
        return w;
    endfunction

    // control bits echoed, flags and id in their fields
    function automatic bus_pkg::reg_data_t expected_status(input logic pwr,
            input axis_pkg::axis_vec_t amp, input axis_pkg::axis_vec_t trip);
        bus_pkg::reg_data_t w;
        w = ctrl_word(pwr, amp);
        w[bus_pkg::STAT_SAFETY_LSB +: axis_pkg::NUM_AXES] = trip;
        w[bus_pkg::STAT_ID_LSB +: bus_pkg::ID_W] = board_id;
        return w;
    endfunction

    function automatic logic ack_of(input logic use_eth);
        return use_eth ? eth_ack : fw_ack;
    endfunction

    task automatic check_value(input bus_pkg::reg_data_t got, input bus_pkg::reg_data_t exp,
                               input string what);
        assert (got === exp) else begin
            err_cnt++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sysclk);
        #2;
    endtask

    // one full req / ack / release / ack low sequence
    task automatic host_access(input logic use_eth, input logic wr, input bus_pkg::reg_addr_t addr,
            input bus_pkg::reg_data_t wdata, output bus_pkg::reg_data_t rdata, output time ack_at);
        int waited;
        waited = 0;
        rdata = '0;
        ack_at = 0;
        @(posedge sysclk);
        #2;
        if (use_eth) begin
            eth_write = wr;
            eth_addr  = addr;
            eth_wdata = wdata;
            eth_req   = 1'b1;
        end else begin
            fw_write = wr;
            fw_addr  = addr;
            fw_wdata = wdata;
            fw_req   = 1'b1;
        end
        while (!ack_of(use_eth) && waited < 20) begin
            wait_cycles(1);
            waited++;
        end
        if (!ack_of(use_eth)) begin
            tmo_cnt++;
            $display("timeout: %s ack never rose at addr %h", use_eth ? "eth" : "fw", addr);
        end else begin
            ack_at = $time;
            rdata  = use_eth ? eth_rdata : fw_rdata;   // valid while ack high
        end
        if (use_eth)
            eth_req = 1'b0;
        else
            fw_req = 1'b0;
        waited = 0;
        while (ack_of(use_eth) && waited < 20) begin
            wait_cycles(1);
            waited++;
        end
        if (ack_of(use_eth)) begin
            tmo_cnt++;
            $display("timeout: %s ack stuck high after req dropped", use_eth ? "eth" : "fw");
        end
    endtask

    task automatic read_reg(input logic use_eth, input bus_pkg::reg_addr_t addr,
                            output bus_pkg::reg_data_t data);
        time t;
        host_access(use_eth, 1'b0, addr, '0, data, t);
    endtask

    task automatic write_reg(input logic use_eth, input bus_pkg::reg_addr_t addr,
                             input bus_pkg::reg_data_t data);
        bus_pkg::reg_data_t unused;
        time t;
        host_access(use_eth, 1'b1, addr, data, unused, t);
    endtask

    // axis 1..4, host alternates with the axis number
    task automatic write_cmd(input int axis, input bus_pkg::reg_data_t data);
        write_reg(axis[0], reg_addr(axis, bus_pkg::OFF_DAC_CMD), data);
        cmd_model[axis-1] = data[axis_pkg::CUR_W-1:0];
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        rst_n     = 1'b0;
        board_id  = 4'h9;
        fw_req    = 1'b0;
        fw_write  = 1'b0;
        fw_addr   = '0;
        fw_wdata  = '0;
        eth_req   = 1'b0;
        eth_write = 1'b0;
        eth_addr  = '0;
        eth_wdata = '0;
        for (int i = 0; i < axis_pkg::NUM_AXES; i++) begin
            cur_fb[i]    = '0;
            cmd_model[i] = '0;
        end
        repeat (2) @(posedge sysclk);
        #2;
        rst_n = 1'b1;

        // reset state
        check_value(32'(fw_ack), '0, "fw ack after reset");
        check_value(32'(eth_ack), '0, "eth ack after reset");
        check_value(32'(amp_enable), '0, "amp enable after reset");
        check_value(32'(pwr_enable), '0, "pwr enable after reset");
        for (int i = 0; i < axis_pkg::NUM_AXES; i++)
            check_value(32'(dac_cmd[i]), '0, $sformatf("axis %0d dac after reset", i + 1));
        read_reg(1'b0, reg_addr(0, bus_pkg::OFF_BOARD_STATUS), rd);
        check_value(rd, expected_status(1'b0, '0, '0), "status after reset");

        // feedback readout, then commands with fb parked at zero
        for (int i = 0; i < axis_pkg::NUM_AXES; i++)
            cur_fb[i] = axis_pkg::cur_t'($random(seed));
        for (int i = 0; i < axis_pkg::NUM_AXES; i++) begin
            read_reg(i[0], reg_addr(i + 1, bus_pkg::OFF_ADC_FB), rd);
            check_value(rd, 32'(cur_fb[i]), $sformatf("axis %0d feedback read", i + 1));
            cur_fb[i] = '0;
        end
        for (int a = 1; a <= axis_pkg::NUM_AXES; a++) begin
            write_cmd(a, $random(seed));
            check_value(32'(dac_cmd[a-1]), 32'(cmd_model[a-1]), $sformatf("axis %0d dac", a));
            read_reg(!a[0], reg_addr(a, bus_pkg::OFF_DAC_CMD), rd);   // other host reads back
            check_value(rd, 32'(cmd_model[a-1]), $sformatf("axis %0d cmd read", a));
        end
        read_reg(1'b1, reg_addr(5, 0), rd);
        check_value(rd, '0, "channel 5 read");
        read_reg(1'b0, reg_addr(15, 1), rd);
        check_value(rd, '0, "channel 15 read");
        read_reg(1'b1, reg_addr(1, 2), rd);
        check_value(rd, '0, "axis offset 2 read");
        read_reg(1'b0, reg_addr(0, 1), rd);
        check_value(rd, '0, "board offset 1 read");

        // board control
        write_reg(1'b1, reg_addr(0, bus_pkg::OFF_BOARD_STATUS), ctrl_word(1'b1, 4'b1011));
        check_value(32'(pwr_enable), 32'd1, "pwr enable set");
        check_value(32'(amp_enable), 32'b1011, "amp enable with power");
        read_reg(1'b0, reg_addr(0, bus_pkg::OFF_BOARD_STATUS), rd);
        check_value(rd, expected_status(1'b1, 4'b1011, '0), "status with power");
        write_reg(1'b0, reg_addr(0, bus_pkg::OFF_BOARD_STATUS), ctrl_word(1'b0, 4'b1011));
        check_value(32'(amp_enable), '0, "amp enable without power");
        write_reg(1'b0, reg_addr(0, bus_pkg::OFF_BOARD_STATUS), ctrl_word(1'b1, 4'hf));

        // safety trip on axis 2, 0x201 is just over 2 * 0x100
        for (int a = 2; a <= axis_pkg::NUM_AXES; a++)
            write_cmd(a, 32'h0000_0100);
        cur_fb[1] = 16'h0201;
        wait_cycles(2 * axis_pkg::OVERCURRENT_CYCLES);
        cur_fb[1] = '0;
        check_value(32'(amp_enable), 32'b1101, "amp enable after trip");
        read_reg(1'b1, reg_addr(0, bus_pkg::OFF_BOARD_STATUS), rd);   // flag sticky with fb gone
        check_value(rd, expected_status(1'b1, 4'hf, 4'b0010), "status after trip");
        write_cmd(2, 32'h0000_0100);
        check_value(32'(amp_enable), 32'hf, "amp enable after rearm");

        // short spike on axis 3, exact 2x limit on axis 4
        cur_fb[2] = 16'h0300;
        wait_cycles(axis_pkg::OVERCURRENT_CYCLES - 2);
        cur_fb[2] = '0;
        cur_fb[3] = 16'h0200;
        wait_cycles(2 * axis_pkg::OVERCURRENT_CYCLES);
        cur_fb[3] = '0;
        read_reg(1'b0, reg_addr(0, bus_pkg::OFF_BOARD_STATUS), rd);
        check_value(rd, expected_status(1'b1, 4'hf, '0), "status after spike and 2x fb");
        check_value(32'(amp_enable), 32'hf, "amp enable after spike and 2x fb");

        // contention, both hosts on the same edge
        fork
            host_access(1'b0, 1'b0, reg_addr(1, bus_pkg::OFF_DAC_CMD), '0, rd_fw, t_fw);
            host_access(1'b1, 1'b0, reg_addr(0, bus_pkg::OFF_BOARD_STATUS), '0, rd_eth, t_eth);
        join
        check_value(rd_fw, 32'(cmd_model[0]), "contention fw read");
        check_value(rd_eth, expected_status(1'b1, 4'hf, '0), "contention eth read");
        assert (t_eth < t_fw) else begin
            err_cnt++;
            $display("Fail %0t: eth ack at %0t did not lead fw ack at %0t", $time, t_eth, t_fw);
        end

        wait_cycles(2);   // let the last assertions sample
        $display("value errors %0d, timeouts %0d, assertion failures %0d",
                 err_cnt, tmo_cnt, u_dut.u_checker.fail_cnt);
        if (err_cnt == 0 && tmo_cnt == 0 && u_dut.u_checker.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/bus_pkg.sv
logic/axis_pkg.sv
logic/reg_bus_if.sv
logic/bus_arbiter.sv
logic/axis_regs.sv
logic/overcurrent_timer.sv
logic/board_regs.sv
logic/motor_ctrl_top.sv
testbench/motor_ctrl_checker.sv
testbench/tb_motor_ctrl.sv

// ==== Bender.yml ====
package:
  name: motor_ctrl

sources:
  # packages first, then interface and modules
  - files:
      - logic/bus_pkg.sv
      - logic/axis_pkg.sv
      - logic/reg_bus_if.sv
      - logic/bus_arbiter.sv
      - logic/axis_regs.sv
      - logic/overcurrent_timer.sv
      - logic/board_regs.sv
      - logic/motor_ctrl_top.sv
  - target: test
    files:
      - testbench/motor_ctrl_checker.sv
      - testbench/tb_motor_ctrl.sv
